// ==== run_sim.sh ====
#!/bin/sh
# build and run the video fetch testbench with Verilator, then grade the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/10ps -f sources.f \
	--top-module video_fetch_tb -o video_fetch_sim > build.log 2>&1 \
	&& ./obj_dir/video_fetch_sim > sim.log 2>&1 \
	|| echo "build or simulation failed, see build.log and sim.log"
grep -q "No errors" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
exit 0

// ==== sim/video_fetch_ref.svh ====
`ifndef VIDEO_FETCH_REF_SVH
`define VIDEO_FETCH_REF_SVH

// fetches on one visible line
function automatic int fetches_per_line(input video_pkg::video_mode_e m);
	if (m == video_pkg::mode_zx || m == video_pkg::mode_p_hmclr)
		return video_pkg::FETCH_ZX;
	else
		return video_pkg::FETCH_WIDE;
endfunction

// zx pixel byte order: third, char line, char row, column
function automatic int zx_pixel_offset(input int y, input int cx);
	return ((y / 64) % 4) * 1024 + (y % 8) * 128 + ((y / 8) % 8) * 16 + cx;
endfunction

// Y inside the text symbol, first visible line is row 0x38
function automatic int expected_text_row(input int vline);
	return (int'(video_pkg::TEXT_ROW_INIT) + 1 + vline) % 8;
endfunction

// DRAM word address of fetch idx in the frame
function automatic int expected_addr(input video_pkg::video_mode_e m, input logic pg,
	input int idx, input int vline);
	int page_bit;
	int cnt;
	int x;
	int ty;
	int y;
	int cx;
	int a;
	page_bit = pg ? 'h4000 : 0;
	cnt = fetches_per_line(m);
	x = idx - vline * cnt; // column within the line
	ty = int'(video_pkg::TEXT_ROW_INIT) + 1 + vline;
	case (m)
		video_pkg::mode_zx:
		begin
			y = (idx / 32) % 256;
			cx = (idx / 2) % 16;
			if (idx % 2 == 1)
				a = 'ha000 + 'hc00 + (y / 8) * 16 + cx; // attribute area
			else
				a = 'ha000 + zx_pixel_offset(y, cx);
		end
		video_pkg::mode_p_16c:
		begin
			y = (idx / 64) % 256;
			cx = (idx / 4) % 16;
			a = 'h8000 + (1 - idx % 2) * 'h2000 + ((idx / 2) % 2) * 'h1000;
			a = a + zx_pixel_offset(y, cx); // plane from low two bits
		end
		video_pkg::mode_p_hmclr:
		begin
			y = (idx / 32) % 256;
			cx = (idx / 2) % 16;
			a = 'ha000 + (idx % 2) * 'h1000 + zx_pixel_offset(y, cx);
		end
		video_pkg::mode_a_16c,
		video_pkg::mode_a_hmclr:
		begin
			a = 'h2000 + (1 - idx % 2) * 'h8000 + ((idx / 2) % 2) * 'h1000 + (idx / 4) % 4096;
		end
		video_pkg::mode_a_text:
		begin
			a = 'h2000 + (1 - x % 2) * 'h8000 + ((x / 2) % 2) * 'h1000;
			a = a + ((ty / 8) % 32) * 32 + (x / 4) % 32; // row, then column
		end
		default:
			a = 0;
	endcase
	return a + page_bit;
endfunction

`endif

// ==== sim/video_fetch_tb.sv ====
`timescale 1ns/10ps

module video_fetch_tb;

	localparam int LINE_CLKS  = video_pkg::H_TOTAL * video_pkg::PIX_DIV;
	localparam int FRAME_CLKS = LINE_CLKS * video_pkg::V_TOTAL;
	localparam int RUN_FRAMES = 2;
	localparam int SEQ_MAX    = RUN_FRAMES * video_pkg::V_VISIBLE * video_pkg::FETCH_WIDE;

	logic                   clk = 1'b0;
	logic                   reset;
	video_pkg::video_mode_e mode;
	logic                   scr_page;
	video_pkg::fetch_req_t  req;
	logic                   req_valid;
	logic                   req_ready = 1'b0;

	integer seed;
	integer rnd;
	logic   random_ready; // back-pressure on
	logic   record_seq;   // keep this run's addresses
	logic   match_seq;    // compare against the kept run
	int     xfer_cnt;
	int     cyc;          // clocks since reset release
	logic [video_pkg::ADDR_W-1:0] golden [0:SEQ_MAX-1];

	`include "video_fetch_ref.svh"

	video_fetch_top uut
	(
		.clk       (clk),
		.reset     (reset),
		.mode      (mode),
		.scr_page  (scr_page),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	// ready is high in reset and never low two cycles in a row
	always @(negedge clk)
	begin
		rnd = $random(seed);
		if (reset || !random_ready || !req_ready)
			req_ready = 1'b1;
		else
			req_ready = rnd[0];
	end

	always @(posedge clk)
	begin
		int cnt;
		int per_frame;
		int idx;
		int vline;
		int line;
		logic held;
		logic [23:0] held_req;
		if (reset)
		begin
			cyc = 0;
			xfer_cnt = 0;
			held = 1'b0;
		end
		else
		begin
			line = (cyc / LINE_CLKS) % video_pkg::V_TOTAL;
			if (held) // stalled last cycle so nothing may move
			begin
				check_value("req_valid held", {31'd0, req_valid}, 1);
				check_value("req held", {8'd0, req}, {8'd0, held_req});
			end
			if (req_valid)
				check_value("req_valid in visible line", {31'd0, (line >= video_pkg::V_FIRST &&
					line < video_pkg::V_FIRST + video_pkg::V_VISIBLE)}, 1);
			if (req_valid && req_ready)
			begin
				cnt = fetches_per_line(mode);
				per_frame = cnt * video_pkg::V_VISIBLE;
				idx = xfer_cnt % per_frame; // restarts every frame
				vline = idx / cnt;
				if (match_seq && xfer_cnt < SEQ_MAX)
					check_value("req.addr vs kept run", {11'd0, req.addr},
						{11'd0, golden[xfer_cnt]});
				check_value("transfer line", line, video_pkg::V_FIRST + vline);
				check_value("transfer frame", cyc / FRAME_CLKS, xfer_cnt / per_frame);
				check_value("req.addr", {11'd0, req.addr},
					expected_addr(mode, scr_page, idx, vline));
				check_value("req.text_row", {29'd0, req.text_row},
					expected_text_row(vline));
				if (record_seq && xfer_cnt < SEQ_MAX)
					golden[xfer_cnt] = req.addr;
				xfer_cnt++;
			end
			held = req_valid && !req_ready;
			held_req = req;
			cyc++;
		end
	end

	task automatic run_scenario(input video_pkg::video_mode_e m, input logic pg,
		input logic rnd_rdy, input logic rec, input logic cmp);
		int wait_cnt;
		int expect_cnt;
		@(negedge clk);
		reset = 1'b1;
		mode = m;
		scr_page = pg;
		random_ready = rnd_rdy;
		record_seq = rec;
		match_seq = cmp;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		expect_cnt = RUN_FRAMES * video_pkg::V_VISIBLE * fetches_per_line(m);

		wait_cnt = 0;
		while (!req_valid)
		begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > FRAME_CLKS)
				stop_on_timeout("first request");
		end
		check_value("first req_valid clock",
			{31'd0, (cyc >= video_pkg::V_FIRST * LINE_CLKS)}, 1);

		wait_cnt = 0;
		while (xfer_cnt < expect_cnt)
		begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > RUN_FRAMES * FRAME_CLKS)
				stop_on_timeout("all transfers");
		end

		wait_cnt = 0;
		while (cyc < RUN_FRAMES * FRAME_CLKS) // let the last frame run out
		begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > FRAME_CLKS)
				stop_on_timeout("end of frame");
		end
	endtask

	initial
	begin
		seed = 32'h951c028f;
		reset = 1'b1;
		mode = video_pkg::mode_zx;
		scr_page = 1'b0;
		random_ready = 1'b0;
		record_seq = 1'b0;
		match_seq = 1'b0;

		run_scenario(video_pkg::mode_zx, 1'b0, 1'b0, 1'b1, 1'b0);
		run_scenario(video_pkg::mode_zx, 1'b0, 1'b1, 1'b0, 1'b1);
		run_scenario(video_pkg::mode_zx, 1'b1, 1'b1, 1'b0, 1'b0);
		run_scenario(video_pkg::mode_p_16c, 1'b0, 1'b1, 1'b0, 1'b0);
		run_scenario(video_pkg::mode_p_hmclr, 1'b1, 1'b1, 1'b0, 1'b0);
		run_scenario(video_pkg::mode_a_16c, 1'b0, 1'b0, 1'b1, 1'b0);
		run_scenario(video_pkg::mode_a_hmclr, 1'b0, 1'b1, 1'b0, 1'b1); // same walk as 16c
		run_scenario(video_pkg::mode_a_text, 1'b1, 1'b1, 1'b0, 1'b0);

		$display("No errors");
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_addrgen.sv
verilog/video_fetch_req.sv
verilog/video_fetch_top.sv
+incdir+sim
sim/video_fetch_tb.sv

// ==== verilog/video_addrgen.sv ====
`timescale 1ns/10ps

module video_addrgen
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          pix_en,
	input  video_pkg::video_mode_e        mode,
	input  logic                          scr_page,
	input  logic                          line_start,
	input  logic                          int_start,
	input  logic                          vpix,
	input  logic                          video_next,
	output logic [video_pkg::ADDR_W-1:0]  video_addr,
	output logic [2:0]                    typos
);

	logic        line_start_r;
	logic        line_init;
	logic        line_init_r;
	logic        frame_init_r;
	logic        gnext;
	logic        tnext;
	logic        ldaddr;
	logic [13:0] gctr;  // graphics fetch index in the frame
	logic [7:0]  tyctr; // text row counter
	logic [6:0]  txctr; // text column counter

	logic [11:0] zx_pix;
	logic [11:0] zx_attr;
	logic [11:0] zx_p16c;
	logic [video_pkg::ADDR_W-1:0] addr_zx;
	logic [video_pkg::ADDR_W-1:0] addr_phm;
	logic [video_pkg::ADDR_W-1:0] addr_p16c;
	logic [video_pkg::ADDR_W-1:0] addr_ag;
	logic [video_pkg::ADDR_W-1:0] addr_at;
	logic [video_pkg::ADDR_W-1:0] addr_sel;

	assign line_init = line_start_r & vpix; // pix tick 1 of a visible line

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			line_start_r <= 1'b0;
			line_init_r  <= 1'b0;
			frame_init_r <= 1'b0;
		end
		else if (pix_en)
		begin
			line_start_r <= line_start;
			line_init_r  <= line_init;
			frame_init_r <= int_start;
		end
	end

	// delayed init loads the first address, video_next the rest
	assign gnext  = video_next | frame_init_r;
	assign tnext  = video_next | line_init_r;
	assign ldaddr = (mode == video_pkg::mode_a_text) ? tnext : gnext;

	always_ff @(posedge clk)
	begin
		if (reset)
			gctr <= 14'd0;
		else if (pix_en)
		begin
			if (int_start)
				gctr <= 14'd0;
			else if (gnext)
				gctr <= gctr + 14'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tyctr <= video_pkg::TEXT_ROW_INIT;
			txctr <= 7'd0;
		end
		else if (pix_en)
		begin
			if (int_start)
				tyctr <= video_pkg::TEXT_ROW_INIT;
			else if (line_init)
				tyctr <= tyctr + 8'd1;

			if (line_init)
				txctr <= 7'd0; // column restarts every line
			else if (tnext)
				txctr <= txctr + 7'd1;
		end
	end

	assign typos = tyctr[2:0];

	// zx screen layout: bit 0 picks pixels or attributes,
	// thirds and character rows are swapped around in the pixel area
	assign zx_pix  = {gctr[12:11], gctr[7:5], gctr[10:8], gctr[4:1]};
	assign zx_attr = {3'b110, gctr[12:8], gctr[4:1]};
	assign zx_p16c = {gctr[13:12], gctr[8:6], gctr[11:9], gctr[5:2]}; // two plane bits below

	assign addr_zx   = {6'b000001, scr_page, 2'b10, (gctr[0] ? zx_attr : zx_pix)};
	assign addr_phm  = {6'b000001, scr_page, 1'b1, gctr[0], zx_pix};
	assign addr_p16c = {6'b000001, scr_page, ~gctr[0], gctr[1], zx_p16c};

	// atm 16c and hardware multicolour walk the same sequence
	assign addr_ag = {5'b00000, ~gctr[0], scr_page, 1'b1, gctr[1], gctr[13:2]};

	// text: X bit 0 picks symbol or attribute plane
	assign addr_at = {5'b00000, ~txctr[0], scr_page, 1'b1, txctr[1], 2'b00,
		tyctr[7:3], txctr[6:2]};

	always_comb
	begin
		case (mode)
			video_pkg::mode_zx:      addr_sel = addr_zx;
			video_pkg::mode_p_16c:   addr_sel = addr_p16c;
			video_pkg::mode_p_hmclr: addr_sel = addr_phm;
			video_pkg::mode_a_16c,
			video_pkg::mode_a_hmclr: addr_sel = addr_ag;
			video_pkg::mode_a_text:  addr_sel = addr_at;
			default:                 addr_sel = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			video_addr <= '0;
		else if (pix_en && ldaddr)
			video_addr <= addr_sel;
	end

endmodule

// ==== verilog/video_fetch_req.sv ====
`timescale 1ns/10ps

module video_fetch_req
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          pix_en,
	input  video_pkg::video_mode_e        mode,
	input  logic                          line_start,
	input  logic                          vpix,
	input  logic [video_pkg::ADDR_W-1:0]  video_addr,
	input  logic [2:0]                    typos,
	output logic                          video_next,
	output video_pkg::fetch_req_t         req,
	output logic                          req_valid,
	input  logic                          req_ready
);

	logic [1:0] tick_cnt;  // pix tick within the line, saturates at 3
	logic [6:0] fetch_cnt; // fetches issued on this line
	logic       win_open;
	logic       slot_free;
	logic       last_fetch;

	assign slot_free  = ~req_valid | req_ready;
	assign video_next = pix_en & win_open & slot_free;
	assign last_fetch = (fetch_cnt == video_pkg::fetch_count(mode) - 7'd1);

	always_ff @(posedge clk)
	begin
		if (reset)
			tick_cnt <= 2'd0;
		else if (pix_en)
		begin
			if (line_start)
				tick_cnt <= 2'd1;
			else if (tick_cnt != 2'd3)
				tick_cnt <= tick_cnt + 2'd1;
		end
	end

	// window runs from pix tick 3 until the line budget is spent
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			win_open  <= 1'b0;
			fetch_cnt <= 7'd0;
		end
		else if (pix_en)
		begin
			if (line_start)
			begin
				win_open  <= 1'b0; // never spill into the next line
				fetch_cnt <= 7'd0;
			end
			else if (tick_cnt == 2'd2 && vpix)
			begin
				win_open  <= 1'b1;
				fetch_cnt <= 7'd0;
			end
			else if (video_next)
			begin
				fetch_cnt <= fetch_cnt + 7'd1;
				if (last_fetch)
					win_open <= 1'b0;
			end
		end
	end

	// request register, held until the DRAM side takes it
	always_ff @(posedge clk)
	begin
		if (reset)
			req_valid <= 1'b0;
		else if (video_next)
			req_valid <= 1'b1;
		else if (req_ready)
			req_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (video_next)
		begin
			req.addr     <= video_addr;
			req.text_row <= typos;
		end
	end

endmodule

// ==== verilog/video_fetch_top.sv ====
`timescale 1ns/10ps

module video_fetch_top
(
	input  logic                   clk,
	input  logic                   reset,
	input  video_pkg::video_mode_e mode,
	input  logic                   scr_page, // must be stable out of reset
	output video_pkg::fetch_req_t  req,
	output logic                   req_valid,
	input  logic                   req_ready
);

	logic                         pix_en;
	logic                         line_start;
	logic                         int_start;
	logic                         vpix;
	logic                         video_next;
	logic [video_pkg::ADDR_W-1:0] video_addr;
	logic [2:0]                   typos;

	video_timing timing
	(
		.clk        (clk),
		.reset      (reset),
		.pix_en     (pix_en),
		.line_start (line_start),
		.int_start  (int_start),
		.vpix       (vpix)
	);

	video_addrgen addrgen
	(
		.clk        (clk),
		.reset      (reset),
		.pix_en     (pix_en),
		.mode       (mode),
		.scr_page   (scr_page),
		.line_start (line_start),
		.int_start  (int_start),
		.vpix       (vpix),
		.video_next (video_next),
		.video_addr (video_addr),
		.typos      (typos)
	);

	video_fetch_req fetch_req
	(
		.clk        (clk),
		.reset      (reset),
		.pix_en     (pix_en),
		.mode       (mode),
		.line_start (line_start),
		.vpix       (vpix),
		.video_addr (video_addr),
		.typos      (typos),
		.video_next (video_next),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready)
	);

endmodule

// ==== verilog/video_pkg.sv ====
package video_pkg;

	// screen modes understood by the address generator
	typedef enum logic [2:0]
	{
		mode_zx      = 3'd0,
		mode_p_16c   = 3'd1,
		mode_p_hmclr = 3'd2,
		mode_a_16c   = 3'd3,
		mode_a_hmclr = 3'd4,
		mode_a_text  = 3'd5
	} video_mode_e;

	localparam int ADDR_W = 21; // DRAM word address

	// one fetch request as seen by the DRAM side
	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;
		logic [2:0]        text_row; // Y inside the text symbol
	} fetch_req_t;

	// frame geometry, kept tiny so full frames run fast
	localparam int PIX_DIV   = 2;   // clk cycles per pix_en
	localparam int H_TOTAL   = 200; // pix ticks per line
	localparam int V_TOTAL   = 12;  // lines per frame
	localparam int V_FIRST   = 2;   // first visible line
	localparam int V_VISIBLE = 8;

	// fetches on each visible line
	localparam int FETCH_ZX   = 32;
	localparam int FETCH_WIDE = 64;

	// text Y counter start, first visible line brings it to 0x38
	localparam logic [7:0] TEXT_ROW_INIT = 8'h37;

	// per-line fetch budget of a mode
	function automatic logic [6:0] fetch_count(input video_mode_e mode);
		case (mode)
			mode_zx,
			mode_p_hmclr:
			begin
				fetch_count = 7'(FETCH_ZX);
			end
			default:
			begin
				fetch_count = 7'(FETCH_WIDE); // 16c, atm gfx and text
			end
		endcase
	endfunction

endpackage

// ==== verilog/video_timing.sv ====
`timescale 1ns/10ps

module video_timing
(
	input  logic clk,
	input  logic reset,
	output logic pix_en,
	output logic line_start,
	output logic int_start,
	output logic vpix
);

	logic [1:0] div_cnt;
	logic [7:0] hcnt;
	logic [3:0] vcnt;
	logic [7:0] hcnt_nxt;
	logic [3:0] vcnt_nxt;
	logic       line_wrap;
	logic       frame_wrap;
	logic       vpix_nxt;

	// pixel clock enable, first tick right after reset goes away
	always_ff @(posedge clk)
	begin
		if (reset)
			div_cnt <= 2'd0;
		else if (div_cnt == 2'(video_pkg::PIX_DIV - 1))
			div_cnt <= 2'd0;
		else
			div_cnt <= div_cnt + 2'd1;
	end

	assign pix_en = (div_cnt == 2'd0);

	assign line_wrap  = (hcnt == 8'(video_pkg::H_TOTAL - 1));
	assign frame_wrap = line_wrap && (vcnt == 4'(video_pkg::V_TOTAL - 1));

	always_comb
	begin
		hcnt_nxt = line_wrap ? 8'd0 : hcnt + 8'd1;
		vcnt_nxt = vcnt;
		if (frame_wrap)
			vcnt_nxt = 4'd0;
		else if (line_wrap)
			vcnt_nxt = vcnt + 4'd1;
	end

	assign vpix_nxt = (vcnt_nxt >= 4'(video_pkg::V_FIRST)) &&
		(vcnt_nxt < 4'(video_pkg::V_FIRST + video_pkg::V_VISIBLE));

	// counters park on the last pixel of the frame during reset,
	// so the first tick after reset starts a new frame
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hcnt <= 8'(video_pkg::H_TOTAL - 1);
			vcnt <= 4'(video_pkg::V_TOTAL - 1);
		end
		else if (pix_en)
		begin
			hcnt <= hcnt_nxt;
			vcnt <= vcnt_nxt;
		end
	end

	// strobes line up with the counter value they describe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			line_start <= 1'b0;
			int_start  <= 1'b0;
			vpix       <= 1'b0;
		end
		else if (pix_en)
		begin
			line_start <= line_wrap;  // hcnt goes to 0
			int_start  <= frame_wrap; // line 0 of the frame
			vpix       <= vpix_nxt;
		end
	end

endmodule
